/* rtl/debug_pkg.sv */
package debug_pkg;

  //////////////////////////////////////////////////
  // Widths.
  //////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;       // One UART character.
  typedef logic [31:0] instr_t;      // One MIPS instruction.
  typedef logic [7:0]  imem_addr_t;  // 256-word instruction memory.

  //////////////////////////////////////////////////
  // UART timing and framing.
  //////////////////////////////////////////////////

  localparam int CLOCKS_PER_BIT  = 16;
  localparam int BYTES_PER_INSTR = 4;

  // Bit-time counter shared by both UARTs.
  typedef logic [$clog2(CLOCKS_PER_BIT)-1:0] tick_t;

  //////////////////////////////////////////////////
  // Host commands.
  //////////////////////////////////////////////////

  localparam byte_t CMD_SOFT_RESET = 8'h00;
  localparam byte_t CMD_LOAD       = 8'h01;
  localparam byte_t CMD_RUN_CONT   = 8'h03;
  localparam byte_t CMD_RUN_STEP   = 8'h07;

  localparam int STEP_MODE_BIT = 2;  // Set in the step-mode start byte.

  // Debug control FSM.
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SOFT_RESET,
    ST_LOAD,
    ST_ACK,
    ST_WAIT_START
  } debug_state_t;

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic             i_clock,
  input  logic             i_reset,
  input  logic             i_rx,
  output debug_pkg::byte_t o_rx_data,
  output logic             o_rx_valid
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_phase_t;

  rx_phase_t        phase;
  logic [1:0]       rx_sync;
  logic             line;
  debug_pkg::tick_t tick_count;
  logic [2:0]       bit_index;
  debug_pkg::byte_t rx_shift;
  logic             half_bit;
  logic             full_bit;

  assign line     = rx_sync[1];
  assign half_bit = (tick_count == debug_pkg::tick_t'(debug_pkg::CLOCKS_PER_BIT / 2 - 1));
  assign full_bit = (tick_count == debug_pkg::tick_t'(debug_pkg::CLOCKS_PER_BIT - 1));

  assign o_rx_data = rx_shift;

  // Line synchronizer, idles high.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], i_rx};
    end
  end

  //////////////////////////////////////////////////
  // Frame FSM.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      phase      <= RX_IDLE;
      tick_count <= '0;
      bit_index  <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (phase)
        RX_IDLE: begin
          tick_count <= '0;
          bit_index  <= '0;
          if (!line) begin
            phase <= RX_START;  // Falling edge seen.
          end
        end
        RX_START: begin
          if (half_bit) begin
            tick_count <= '0;
            // A high line here was only a glitch.
            phase <= line ? RX_IDLE : RX_DATA;
          end else begin
            tick_count <= tick_count + 1'b1;
          end
        end
        RX_DATA: begin
          if (full_bit) begin
            tick_count <= '0;
            bit_index  <= bit_index + 1'b1;
            if (bit_index == 3'd7) begin
              phase <= RX_STOP;
            end
          end else begin
            tick_count <= tick_count + 1'b1;
          end
        end
        RX_STOP: begin
          if (full_bit) begin
            phase      <= RX_IDLE;
            o_rx_valid <= line;  // Framing error drops the byte.
          end else begin
            tick_count <= tick_count + 1'b1;
          end
        end
        default: phase <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge i_clock) begin
    if ((phase == RX_DATA) && full_bit) begin
      rx_shift <= {line, rx_shift[7:1]};
    end
  end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic             i_clock,
  input  logic             i_reset,
  input  logic             i_tx_start,
  input  debug_pkg::byte_t i_tx_data,
  output logic             o_tx,
  output logic             o_tx_busy,
  output logic             o_tx_done
);

  logic [9:0]       frame_shift;  // Stop, data, start.
  debug_pkg::tick_t tick_count;
  logic [3:0]       bit_count;
  logic             bit_end;

  assign bit_end = (tick_count == debug_pkg::tick_t'(debug_pkg::CLOCKS_PER_BIT - 1));
  assign o_tx    = frame_shift[0];

  //////////////////////////////////////////////////
  // Frame shifter.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      frame_shift <= '1;  // Line idles high.
      tick_count  <= '0;
      bit_count   <= '0;
      o_tx_busy   <= 1'b0;
      o_tx_done   <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      if (!o_tx_busy) begin
        if (i_tx_start) begin
          frame_shift <= {1'b1, i_tx_data, 1'b0};
          tick_count  <= '0;
          bit_count   <= '0;
          o_tx_busy   <= 1'b1;
        end
      end else if (bit_end) begin
        tick_count  <= '0;
        frame_shift <= {1'b1, frame_shift[9:1]};  // Refill with idle level.
        if (bit_count == 4'd9) begin
          o_tx_busy <= 1'b0;  // Stop bit done.
          o_tx_done <= 1'b1;
        end else begin
          bit_count <= bit_count + 1'b1;
        end
      end else begin
        tick_count <= tick_count + 1'b1;
      end
    end
  end

endmodule

/* rtl/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler (
  input  logic              i_clock,
  input  logic              i_reset,
  input  logic              i_collect,
  input  logic              i_rx_valid,
  input  debug_pkg::byte_t  i_rx_data,
  output debug_pkg::instr_t o_word,
  output logic              o_word_valid
);

  logic [1:0]        byte_count;
  debug_pkg::instr_t word_shift;
  logic              take_byte;

  assign take_byte = i_collect && i_rx_valid;
  assign o_word    = word_shift;

  // Byte counter.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_count   <= '0;
      o_word_valid <= 1'b0;
    end else begin
      o_word_valid <= 1'b0;
      if (!i_collect) begin
        byte_count <= '0;  // Each load starts on a word boundary.
      end else if (i_rx_valid) begin
        if (byte_count == 2'(debug_pkg::BYTES_PER_INSTR - 1)) begin
          byte_count   <= '0;
          o_word_valid <= 1'b1;
        end else begin
          byte_count <= byte_count + 1'b1;
        end
      end
    end
  end

  // MSB first, so earlier bytes move up.
  always_ff @(posedge i_clock) begin
    if (take_byte) begin
      word_shift <= {word_shift[$bits(debug_pkg::instr_t)-$bits(debug_pkg::byte_t)-1:0],
                     i_rx_data};
    end
  end

endmodule

/* rtl/instr_memory.sv */
`timescale 1ns/1ps

module instr_memory (
  input  logic                  i_clock,
  input  logic                  i_write,
  input  debug_pkg::imem_addr_t i_write_addr,
  input  debug_pkg::instr_t     i_write_data,
  input  debug_pkg::imem_addr_t i_read_addr,
  output debug_pkg::instr_t     o_read_data
);

  // One word per address.
  debug_pkg::instr_t mem [2**$bits(debug_pkg::imem_addr_t)];

  // Loader side.
  always_ff @(posedge i_clock) begin
    if (i_write) begin
      mem[i_write_addr] <= i_write_data;
    end
  end

  // Fetch side, one cycle latency.
  always_ff @(posedge i_clock) begin
    o_read_data <= mem[i_read_addr];
  end

endmodule

/* rtl/debug_control.sv */
`timescale 1ns/1ps

module debug_control (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_rx_valid,
  input  debug_pkg::byte_t      i_rx_data,
  input  logic                  i_word_valid,
  input  debug_pkg::instr_t     i_word,
  input  logic                  i_tx_done,
  output logic                  o_collect,
  output logic                  o_mem_write,
  output debug_pkg::imem_addr_t o_mem_addr,
  output debug_pkg::instr_t     o_mem_data,
  output logic                  o_tx_start,
  output debug_pkg::byte_t      o_tx_data,
  output logic                  o_cpu_reset_n,
  output logic                  o_cpu_start,
  output logic                  o_step_mode
);

  debug_pkg::debug_state_t state;
  debug_pkg::imem_addr_t   write_addr;  // Doubles as words written.
  logic                    is_halt;
  logic                    run_cmd;
  logic                    halt_seen;
  logic                    start_seen;

  assign is_halt = (i_word == '0);
  assign run_cmd = i_rx_valid && ((i_rx_data == debug_pkg::CMD_RUN_CONT) ||
                                  (i_rx_data == debug_pkg::CMD_RUN_STEP));

  assign halt_seen  = (state == debug_pkg::ST_LOAD) && i_word_valid && is_halt;
  assign start_seen = (state == debug_pkg::ST_WAIT_START) && run_cmd;

  assign o_collect     = (state == debug_pkg::ST_LOAD);
  assign o_cpu_reset_n = (state != debug_pkg::ST_SOFT_RESET);  // Active low.
  assign o_mem_addr    = write_addr;

  //////////////////////////////////////////////////
  // Command FSM.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state <= debug_pkg::ST_IDLE;
    end else begin
      case (state)
        debug_pkg::ST_IDLE: begin
          if (i_rx_valid && (i_rx_data == debug_pkg::CMD_SOFT_RESET)) begin
            state <= debug_pkg::ST_SOFT_RESET;
          end
        end
        debug_pkg::ST_SOFT_RESET: begin
          // Processor stays held until a load begins.
          if (i_rx_valid && (i_rx_data == debug_pkg::CMD_LOAD)) begin
            state <= debug_pkg::ST_LOAD;
          end
        end
        debug_pkg::ST_LOAD: begin
          if (halt_seen) begin
            state <= debug_pkg::ST_ACK;
          end
        end
        debug_pkg::ST_ACK: begin
          if (i_tx_done) begin
            state <= debug_pkg::ST_WAIT_START;
          end
        end
        debug_pkg::ST_WAIT_START: begin
          if (run_cmd) begin
            state <= debug_pkg::ST_IDLE;
          end
        end
        default: state <= debug_pkg::ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Memory write and address counter.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      o_mem_write <= 1'b0;
      write_addr  <= '0;
    end else begin
      o_mem_write <= (state == debug_pkg::ST_LOAD) && i_word_valid;
      if (state == debug_pkg::ST_SOFT_RESET) begin
        write_addr <= '0;  // Next load starts at zero.
      end else if (o_mem_write) begin
        write_addr <= write_addr + 1'b1;  // Wraps after 256 words.
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_word_valid) begin
      o_mem_data <= i_word;
    end
  end

  //////////////////////////////////////////////////
  // Acknowledge and processor start.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      o_tx_start  <= 1'b0;
      o_cpu_start <= 1'b0;
      o_step_mode <= 1'b0;
    end else begin
      o_tx_start  <= halt_seen;
      o_cpu_start <= start_seen;
      if (start_seen) begin
        o_step_mode <= i_rx_data[debug_pkg::STEP_MODE_BIT];
      end
    end
  end

  // Count includes the halt word not yet written.
  always_ff @(posedge i_clock) begin
    if (halt_seen) begin
      o_tx_data <= debug_pkg::byte_t'(write_addr + 1'b1);
    end
  end

endmodule

/* rtl/debug_loader_top.sv */
`timescale 1ns/1ps

module debug_loader_top (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_uart_rx,
  input  debug_pkg::imem_addr_t i_fetch_addr,
  output logic                  o_uart_tx,
  output debug_pkg::instr_t     o_fetch_instr,
  output logic                  o_cpu_reset_n,
  output logic                  o_cpu_start,
  output logic                  o_step_mode
);

  debug_pkg::byte_t      rx_data;
  logic                  rx_valid;
  logic                  collect;
  debug_pkg::instr_t     word;
  logic                  word_valid;
  logic                  mem_write;
  debug_pkg::imem_addr_t mem_addr;
  debug_pkg::instr_t     mem_data;
  logic                  tx_start;
  debug_pkg::byte_t      tx_data;
  logic                  tx_done;

  //////////////////////////////////////////////////
  // Serial side.
  //////////////////////////////////////////////////

  uart_rx u_uart_rx (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rx       (i_uart_rx),
    .o_rx_data  (rx_data),
    .o_rx_valid (rx_valid)
  );

  uart_tx u_uart_tx (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_tx_start (tx_start),
    .i_tx_data  (tx_data),
    .o_tx       (o_uart_tx),
    .o_tx_busy  (),              // Control waits on done instead.
    .o_tx_done  (tx_done)
  );

  word_assembler u_word_assembler (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_collect    (collect),
    .i_rx_valid   (rx_valid),
    .i_rx_data    (rx_data),
    .o_word       (word),
    .o_word_valid (word_valid)
  );

  //////////////////////////////////////////////////
  // Control and program memory.
  //////////////////////////////////////////////////

  debug_control u_debug_control (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_rx_valid    (rx_valid),
    .i_rx_data     (rx_data),
    .i_word_valid  (word_valid),
    .i_word        (word),
    .i_tx_done     (tx_done),
    .o_collect     (collect),
    .o_mem_write   (mem_write),
    .o_mem_addr    (mem_addr),
    .o_mem_data    (mem_data),
    .o_tx_start    (tx_start),
    .o_tx_data     (tx_data),
    .o_cpu_reset_n (o_cpu_reset_n),
    .o_cpu_start   (o_cpu_start),
    .o_step_mode   (o_step_mode)
  );

  instr_memory u_instr_memory (
    .i_clock      (i_clock),
    .i_write      (mem_write),
    .i_write_addr (mem_addr),
    .i_write_data (mem_data),
    .i_read_addr  (i_fetch_addr),
    .o_read_data  (o_fetch_instr)
  );

endmodule

/* bench/debug_loader_tb.sv */
`timescale 1ns/1ps

module debug_loader_tb;

  localparam int BIT_CLOCKS = debug_pkg::CLOCKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = 80 * 10 * BIT_CLOCKS * 3 / 2;  // About 80 frames, 50% margin.

  logic                  i_clock;
  logic                  i_reset;
  logic                  i_uart_rx;
  debug_pkg::imem_addr_t i_fetch_addr;
  logic                  o_uart_tx;
  debug_pkg::instr_t     o_fetch_instr;
  logic                  o_cpu_reset_n;
  logic                  o_cpu_start;
  logic                  o_step_mode;

  int                error_count;
  int                test_errors;
  int                pass_count;
  int                fail_count;
  int                cycle_count;
  int                start_pulses = 0;
  debug_pkg::instr_t program_q[$];   // Words of the next load, halt excluded.
  debug_pkg::instr_t mem_model[256];
  bit                written[256];
  debug_pkg::byte_t  ack_byte;
  bit                ack_seen;

  debug_loader_top u_dut (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_uart_rx     (i_uart_rx),
    .i_fetch_addr  (i_fetch_addr),
    .o_uart_tx     (o_uart_tx),
    .o_fetch_instr (o_fetch_instr),
    .o_cpu_reset_n (o_cpu_reset_n),
    .o_cpu_start   (o_cpu_start),
    .o_step_mode   (o_step_mode)
  );

  initial begin
    i_clock = 1'b0;
    forever #50 i_clock = ~i_clock;
  end

  always @(posedge i_clock) begin
    if (o_cpu_start) start_pulses <= start_pulses + 1;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Checks and bookkeeping.
  //////////////////////////////////////////////////

  task automatic record_error();
    error_count++;
    test_errors++;
  endtask

  task automatic compare_instr(input string name, input debug_pkg::instr_t expected,
                               input debug_pkg::instr_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      record_error();
    end
  endtask

  task automatic compare_byte(input string name, input debug_pkg::byte_t expected,
                              input debug_pkg::byte_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      record_error();
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      record_error();
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: FAIL with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic settle();
    repeat (4) @(negedge i_clock);
  endtask

  //////////////////////////////////////////////////
  // UART driver and monitor.
  //////////////////////////////////////////////////

  task automatic send_byte(input debug_pkg::byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};  // Stop, data LSB first, start.
    for (int i = 0; i < 10; i++) begin
      @(negedge i_clock);
      i_uart_rx = frame[i];
      repeat (BIT_CLOCKS - 1) @(negedge i_clock);
    end
  endtask

  task automatic receive_byte(output debug_pkg::byte_t data, output bit seen);
    int waited;
    data   = '0;
    seen   = 1'b0;
    waited = 0;
    while ((o_uart_tx !== 1'b0) && (waited < 2 * 10 * BIT_CLOCKS)) begin
      @(negedge i_clock);
      waited++;
    end
    if (o_uart_tx !== 1'b0) begin
      $display("Error: no acknowledge byte on the transmit line");
      record_error();
    end else begin
      repeat (BIT_CLOCKS / 2) @(negedge i_clock);  // Middle of the start bit.
      if (o_uart_tx !== 1'b0) begin
        $display("Error: acknowledge start bit did not stay low");
        record_error();
      end
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLOCKS) @(negedge i_clock);
        data[i] = o_uart_tx;
      end
      repeat (BIT_CLOCKS) @(negedge i_clock);
      if (o_uart_tx !== 1'b1) begin
        $display("Error: acknowledge stop bit was low");
        record_error();
      end
      seen = 1'b1;
    end
  endtask

  // Sends program_q and the halt word; the monitor starts with the last byte.
  task automatic send_program();
    debug_pkg::byte_t      bytes_q[$];
    debug_pkg::instr_t     words[$];
    debug_pkg::imem_addr_t addr;
    words = program_q;
    words.push_back('0);
    addr = '0;
    foreach (words[w]) begin
      for (int b = debug_pkg::BYTES_PER_INSTR - 1; b >= 0; b--) begin
        bytes_q.push_back(words[w][8*b +: 8]);  // MSB first.
      end
      mem_model[addr] = words[w];
      written[addr]   = 1'b1;
      addr            = addr + 1'b1;
    end
    for (int i = 0; i < bytes_q.size() - 1; i++) begin
      send_byte(bytes_q[i]);
    end
    fork
      send_byte(bytes_q[bytes_q.size() - 1]);
      receive_byte(ack_byte, ack_seen);
    join
  endtask

  task automatic load_program();
    send_byte(debug_pkg::CMD_SOFT_RESET);
    send_byte(debug_pkg::CMD_LOAD);
    send_program();
  endtask

  task automatic random_words(input int count);
    debug_pkg::instr_t w;
    program_q.delete();
    repeat (count) begin
      w = $urandom;
      while (w == '0) w = $urandom;  // Zero would end the load early.
      program_q.push_back(w);
    end
  endtask

  // Fetch port has one cycle of latency.
  task automatic check_memory();
    for (int i = 0; i < 256; i++) begin
      if (written[i]) begin
        @(negedge i_clock);
        i_fetch_addr = debug_pkg::imem_addr_t'(i);
        @(negedge i_clock);
        compare_instr($sformatf("o_fetch_instr[%0d]", i), mem_model[i], o_fetch_instr);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests.
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    compare_bit("o_cpu_reset_n", 1'b1, o_cpu_reset_n);
    compare_bit("o_cpu_start", 1'b0, o_cpu_start);
    compare_bit("o_step_mode", 1'b0, o_step_mode);
    compare_bit("o_uart_tx", 1'b1, o_uart_tx);
    end_test("reset values");
  endtask

  task automatic test_soft_reset();
    send_byte(debug_pkg::CMD_SOFT_RESET);
    settle();
    compare_bit("o_cpu_reset_n", 1'b0, o_cpu_reset_n);
    send_byte(8'h05);
    settle();
    compare_bit("o_cpu_reset_n", 1'b0, o_cpu_reset_n);  // Stray byte keeps the hold.
    send_byte(debug_pkg::CMD_LOAD);
    settle();
    compare_bit("o_cpu_reset_n", 1'b1, o_cpu_reset_n);
    program_q.delete();
    send_program();  // Leave the load with a bare halt word.
    compare_byte("acknowledge", debug_pkg::byte_t'(program_q.size() + 1), ack_byte);
    send_byte(debug_pkg::CMD_RUN_CONT);
    end_test("soft reset");
  endtask

  task automatic test_idle_bytes();
    send_byte(8'h05);
    settle();
    compare_bit("o_cpu_reset_n", 1'b1, o_cpu_reset_n);
    send_byte(debug_pkg::CMD_LOAD);
    settle();
    compare_bit("o_cpu_reset_n", 1'b1, o_cpu_reset_n);
    program_q.delete();
    load_program();
    compare_byte("acknowledge", debug_pkg::byte_t'(program_q.size() + 1), ack_byte);
    send_byte(debug_pkg::CMD_RUN_CONT);
    end_test("ignored bytes in idle");
  endtask

  task automatic test_load_readback();
    random_words(8);
    load_program();
    check_memory();
    end_test("load and read back");
  endtask

  task automatic test_acknowledge();
    compare_bit("acknowledge received", 1'b1, ack_seen);
    compare_byte("acknowledge", debug_pkg::byte_t'(program_q.size() + 1), ack_byte);
    end_test("acknowledge");
  endtask

  task automatic test_start_modes();
    int pulses_before;
    pulses_before = start_pulses;
    send_byte(debug_pkg::CMD_RUN_STEP);
    settle();
    compare_byte("o_cpu_start pulses", 8'd1, debug_pkg::byte_t'(start_pulses - pulses_before));
    compare_bit("o_step_mode", 1'b1, o_step_mode);  // 07h selects step mode.
    random_words(3);  // Shorter than the last program.
    load_program();
    compare_byte("acknowledge", debug_pkg::byte_t'(program_q.size() + 1), ack_byte);
    pulses_before = start_pulses;
    send_byte(debug_pkg::CMD_RUN_CONT);
    settle();
    compare_byte("o_cpu_start pulses", 8'd1, debug_pkg::byte_t'(start_pulses - pulses_before));
    compare_bit("o_step_mode", 1'b0, o_step_mode);
    check_memory();
    end_test("start modes");
  endtask

  initial begin
    void'($urandom(32'h5fd2));
    error_count  = 0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    i_reset      = 1'b0;
    i_uart_rx    = 1'b1;  // Idle line.
    i_fetch_addr = '0;
    repeat (10) @(negedge i_clock);
    i_reset = 1'b1;
    settle();
    test_reset_values();
    test_soft_reset();
    test_idle_bytes();
    test_load_readback();
    test_acknowledge();
    test_start_modes();
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* debug_loader_top.f */
rtl/debug_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/word_assembler.sv
rtl/instr_memory.sv
rtl/debug_control.sv
rtl/debug_loader_top.sv
bench/debug_loader_tb.sv

/* Makefile */
# Verilator build and run of the debug loader testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module debug_loader_tb -f debug_loader_top.f -Mdir obj_dir
	./obj_dir/Vdebug_loader_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
